//--- logic/alu_station.sv
module alu_station
(
	input logic clk,
	input logic arst_n,
	rs_issue_if.station rs,
	input logic load,
	input lc3b_types::cdb_t cdb_in,
	input logic grant,
	output logic busy,
	output logic result_ready,
	output lc3b_types::lc3b_word result,
	output lc3b_types::lc3b_rob_addr result_tag
);
import lc3b_types::*;

lc3b_opcode op;
lc3b_word vj;
lc3b_word vk;
lc3b_rob_addr qj;
lc3b_rob_addr qk;
logic valid_j;
logic valid_k;
logic snoop_j;
logic snoop_k;
logic fire;
lc3b_word alu_out;

// Missing operand shows up on the bus
assign snoop_j = busy && !valid_j && cdb_in.valid && (cdb_in.tag == qj);
assign snoop_k = busy && !valid_k && cdb_in.valid && (cdb_in.tag == qk);
assign fire = busy && valid_j && valid_k && !result_ready;

always_comb
begin
	case (op)
		op_add: alu_out = vj + vk;
		op_and: alu_out = vj & vk;
		default: alu_out = ~vj; // op_not
	endcase
end

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
	begin
		busy <= 1'b0;
		result_ready <= 1'b0;
		valid_j <= 1'b0;
		valid_k <= 1'b0;
	end
	else if (load)
	begin
		busy <= 1'b1;
		result_ready <= 1'b0;
		valid_j <= rs.valid_j;
		valid_k <= rs.valid_k;
	end
	else
	begin
		if (snoop_j)
			valid_j <= 1'b1;
		if (snoop_k)
			valid_k <= 1'b1;
		if (fire)
			result_ready <= 1'b1;
		if (grant)
		begin
			busy <= 1'b0; // Result is on the bus this cycle
			result_ready <= 1'b0;
		end
	end
end

always_ff @(posedge clk)
begin
	if (load)
	begin
		op <= rs.op;
		vj <= rs.vj;
		vk <= rs.vk;
		qj <= rs.qj;
		qk <= rs.qk;
		result_tag <= rs.dest;
	end
	else
	begin
		if (snoop_j)
			vj <= cdb_in.data;
		if (snoop_k)
			vk <= cdb_in.data;
		if (fire)
			result <= alu_out;
	end
end

assert property (@(posedge clk) disable iff (!arst_n) load |-> !busy);

// Arbiter only grants a held result
assert property (@(posedge clk) disable iff (!arst_n) grant |-> result_ready);

endmodule

//--- logic/cdb_arbiter.sv
`include "ooo_defines.svh"

module cdb_arbiter
(
	input logic clk,
	input logic arst_n,
	input logic [`NUM_RS-1:0] request,
	input lc3b_types::lc3b_word result [`NUM_RS],
	input lc3b_types::lc3b_rob_addr result_tag [`NUM_RS],
	output logic [`NUM_RS-1:0] grant,
	output lc3b_types::cdb_t cdb
);
import lc3b_types::*;

localparam int PTR_W = $clog2(`NUM_RS);

logic [PTR_W-1:0] ptr;    // Highest priority requester
logic [PTR_W-1:0] winner;

// Scan from farthest to nearest so the one closest to ptr wins
always_comb
begin
	int idx;
	grant = '0;
	winner = ptr;
	for (int i = `NUM_RS-1; i >= 0; i--)
	begin
		idx = int'(ptr) + i;
		if (idx >= `NUM_RS)
			idx = idx - `NUM_RS;
		if (request[idx])
		begin
			grant = '0;
			grant[idx] = 1'b1;
			winner = PTR_W'(idx);
		end
	end
end

assign cdb = '{valid: |grant, tag: result_tag[winner], data: result[winner]};

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
		ptr <= '0;
	else if (|grant)
		ptr <= (winner == PTR_W'(`NUM_RS-1)) ? '0 : winner + 1'b1; // Winner goes last
end

assert property (@(posedge clk) disable iff (!arst_n) $onehot0(grant));

endmodule

//--- logic/issue_control.sv
`include "ooo_defines.svh"

module issue_control
(
	input logic clk,
	input logic arst_n,
	// Fetch side
	input lc3b_types::lc3b_word instr,
	input logic instr_is_new,
	// Bus snoop for results broadcast this cycle
	input lc3b_types::cdb_t cdb_in,
	// Station and ROB status
	input logic [`NUM_RS-1:0] rs_busy,
	input logic rob_full,
	input lc3b_types::lc3b_rob_addr rob_addr,
	input lc3b_types::regfile_t sr1_in,
	input lc3b_types::regfile_t sr2_in,
	input lc3b_types::lc3b_word rob_sr1_value,
	input lc3b_types::lc3b_word rob_sr2_value,
	input logic rob_sr1_valid,
	input logic rob_sr2_valid,
	// To the stations
	rs_issue_if.issuer rs,
	// To the ROB
	output logic rob_write_enable,
	output lc3b_types::lc3b_opcode rob_opcode,
	output lc3b_types::lc3b_reg rob_dest,
	// To the register status file
	output lc3b_types::lc3b_reg sr1,
	output lc3b_types::lc3b_reg sr2,
	output lc3b_types::lc3b_reg reg_dest,
	output logic ld_reg_busy_dest,
	output lc3b_types::lc3b_rob_addr reg_rob_entry,
	output logic issue_ready
);
import lc3b_types::*;

lc3b_opcode opcode;
lc3b_reg dest_reg;
lc3b_word sext5;
logic is_alu;
logic imm_k;
logic take;
logic [`NUM_RS-1:0] free_sel;
logic j_valid;
logic k_valid;
lc3b_word j_value;
lc3b_word k_value;
lc3b_rob_addr j_tag;
lc3b_rob_addr k_tag;

// Register file, then bus, then ROB, else wait on the tag
function automatic void resolve(
	input regfile_t src,
	input lc3b_word rob_value,
	input logic rob_valid,
	input cdb_t cdb,
	output logic valid,
	output lc3b_word value,
	output lc3b_rob_addr tag
);
	valid = 1'b1;
	value = src.data;
	tag = src.rob_entry;
	if (src.busy)
	begin
		if (cdb.valid && cdb.tag == src.rob_entry)
			value = cdb.data;
		else if (rob_valid)
			value = rob_value;
		else
		begin
			valid = 1'b0;
			value = '0;
		end
	end
endfunction

assign opcode = lc3b_opcode'(instr[15:12]);
assign dest_reg = instr[11:9];
assign sr1 = instr[8:6];
assign sr2 = instr[2:0];
assign sext5 = {{(`WORD_W-5){instr[4]}}, instr[4:0]};

assign issue_ready = !rob_full && !(&rs_busy);
assign is_alu = (opcode == op_add) || (opcode == op_and) || (opcode == op_not);
assign take = issue_ready && instr_is_new && is_alu; // Other opcodes are dropped
assign imm_k = instr[5] || (opcode == op_not);      // NOT has no second source
assign free_sel = ~rs_busy & (rs_busy + 1'b1);      // Lowest clear bit

always_comb
begin
	resolve(sr1_in, rob_sr1_value, rob_sr1_valid, cdb_in, j_valid, j_value, j_tag);
	resolve(sr2_in, rob_sr2_value, rob_sr2_valid, cdb_in, k_valid, k_value, k_tag);
end

assign rs.op = opcode;
assign rs.vj = j_value;
assign rs.qj = j_tag;
assign rs.valid_j = j_valid;
assign rs.vk = imm_k ? sext5 : k_value;
assign rs.qk = k_tag;
assign rs.valid_k = imm_k || k_valid;
assign rs.dest = rob_addr;
assign rs.load = take ? free_sel : '0;

assign rob_write_enable = take;
assign rob_opcode = opcode;
assign rob_dest = dest_reg;

assign reg_dest = dest_reg;
assign ld_reg_busy_dest = take;
assign reg_rob_entry = rob_addr;

// Nothing is allocated on a stalled or empty cycle
assert property (@(posedge clk) disable iff (!arst_n)
	!(issue_ready && instr_is_new) |-> !(rob_write_enable || ld_reg_busy_dest || (|rs.load)));

endmodule

//--- logic/lc3b_types.sv
`include "ooo_defines.svh"

package lc3b_types;

typedef logic [`WORD_W-1:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
typedef logic [`TAG_W-1:0] lc3b_rob_addr;

// LC-3b opcode field from instr[15:12]
typedef enum logic [3:0] {
	op_br   = 4'b0000,
	op_add  = 4'b0001,
	op_ldb  = 4'b0010,
	op_stb  = 4'b0011,
	op_jsr  = 4'b0100,
	op_and  = 4'b0101,
	op_ldr  = 4'b0110,
	op_str  = 4'b0111,
	op_rti  = 4'b1000,
	op_not  = 4'b1001,
	op_ldi  = 4'b1010,
	op_sti  = 4'b1011,
	op_jmp  = 4'b1100,
	op_shf  = 4'b1101,
	op_lea  = 4'b1110,
	op_trap = 4'b1111
} lc3b_opcode;

// Common data bus word
typedef struct packed {
	logic valid;
	lc3b_rob_addr tag;
	lc3b_word data;
} cdb_t;

typedef struct packed {
	logic busy;              // Value still in flight
	lc3b_rob_addr rob_entry; // Producing ROB entry
	lc3b_word data;
} regfile_t;

endpackage

//--- logic/ooo_core.sv
`include "ooo_defines.svh"

module ooo_core
(
	input logic clk,
	input logic arst_n,
	input lc3b_types::lc3b_word instr,
	input logic instr_is_new,
	output logic issue_ready,
	output logic commit_valid,
	output lc3b_types::lc3b_reg commit_reg,
	output lc3b_types::lc3b_word commit_value
);
import lc3b_types::*;

rs_issue_if rs_bus ();

cdb_t cdb;
logic [`NUM_RS-1:0] rs_busy;
logic [`NUM_RS-1:0] rs_ready;
logic [`NUM_RS-1:0] rs_grant;
lc3b_word rs_result [`NUM_RS];
lc3b_rob_addr rs_tag [`NUM_RS];
logic rob_full;
lc3b_rob_addr rob_addr;
logic rob_write_enable;
lc3b_opcode rob_opcode;
lc3b_reg rob_dest;
lc3b_word rob_sr1_value;
lc3b_word rob_sr2_value;
logic rob_sr1_valid;
logic rob_sr2_valid;
lc3b_rob_addr commit_tag;
regfile_t sr1_status;
regfile_t sr2_status;
lc3b_reg sr1;
lc3b_reg sr2;
lc3b_reg reg_dest;
logic ld_reg_busy_dest;
lc3b_rob_addr reg_rob_entry;

issue_control issue_control_inst (
	.clk, .arst_n, .instr, .instr_is_new,
	.cdb_in(cdb), .rs_busy, .rob_full, .rob_addr,
	.sr1_in(sr1_status), .sr2_in(sr2_status),
	.rob_sr1_value, .rob_sr2_value, .rob_sr1_valid, .rob_sr2_valid,
	.rs(rs_bus),
	.rob_write_enable, .rob_opcode, .rob_dest,
	.sr1, .sr2, .reg_dest, .ld_reg_busy_dest, .reg_rob_entry,
	.issue_ready
);

reg_status_file reg_status_file_inst (
	.clk, .arst_n, .sr1, .sr2,
	.dest(reg_dest), .ld_busy(ld_reg_busy_dest), .rob_entry(reg_rob_entry),
	.commit_valid, .commit_reg, .commit_tag, .commit_value,
	.sr1_out(sr1_status), .sr2_out(sr2_status)
);

// ROB operand lookup follows the producer tags from the register status
reorder_buffer reorder_buffer_inst (
	.clk, .arst_n,
	.write_enable(rob_write_enable), .opcode(rob_opcode), .dest(rob_dest),
	.cdb_in(cdb),
	.sr1_tag(sr1_status.rob_entry), .sr2_tag(sr2_status.rob_entry),
	.rob_addr, .full(rob_full),
	.sr1_value(rob_sr1_value), .sr2_value(rob_sr2_value),
	.sr1_valid(rob_sr1_valid), .sr2_valid(rob_sr2_valid),
	.commit_valid, .commit_reg, .commit_tag, .commit_value
);

for (genvar i = 0; i < `NUM_RS; i++)
begin : g_station
	alu_station alu_station_inst (
		.clk, .arst_n,
		.rs(rs_bus), .load(rs_bus.load[i]),
		.cdb_in(cdb), .grant(rs_grant[i]),
		.busy(rs_busy[i]), .result_ready(rs_ready[i]),
		.result(rs_result[i]), .result_tag(rs_tag[i])
	);
end

cdb_arbiter cdb_arbiter_inst (
	.clk, .arst_n,
	.request(rs_ready), .result(rs_result), .result_tag(rs_tag),
	.grant(rs_grant), .cdb
);

endmodule

//--- logic/ooo_defines.svh
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// Data path width
`define WORD_W 16

// ROB depth with TAG_W as its log2
`define ROB_DEPTH 8
`define TAG_W 3

// ALU reservation stations
`define NUM_RS 3

`endif

//--- logic/ooo_ifs.sv
`include "ooo_defines.svh"

// Dispatch from the issue controller to the ALU stations
interface rs_issue_if;
import lc3b_types::*;

lc3b_opcode op;
lc3b_word vj;
lc3b_word vk;
lc3b_rob_addr qj;          // Producer of J when not valid
lc3b_rob_addr qk;
logic valid_j;
logic valid_k;
lc3b_rob_addr dest;        // ROB entry for the result
logic [`NUM_RS-1:0] load;  // One-hot station select

modport issuer(output op, vj, vk, qj, qk, valid_j, valid_k, dest, load);

// Each station gets its load bit on its own port
modport station(input op, vj, vk, qj, qk, valid_j, valid_k, dest);

endinterface

//--- logic/reg_status_file.sv
module reg_status_file
(
	input logic clk,
	input logic arst_n,
	input lc3b_types::lc3b_reg sr1,
	input lc3b_types::lc3b_reg sr2,
	input lc3b_types::lc3b_reg dest,
	input logic ld_busy,
	input lc3b_types::lc3b_rob_addr rob_entry,
	input logic commit_valid,
	input lc3b_types::lc3b_reg commit_reg,
	input lc3b_types::lc3b_rob_addr commit_tag,
	input lc3b_types::lc3b_word commit_value,
	output lc3b_types::regfile_t sr1_out,
	output lc3b_types::regfile_t sr2_out
);
import lc3b_types::*;

lc3b_word data [8];
logic [7:0] busy;
lc3b_rob_addr producer [8];

// Architectural state starts at zero
always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
	begin
		busy <= '0;
		for (int i = 0; i < 8; i++)
			data[i] <= '0;
	end
	else
	begin
		if (commit_valid)
		begin
			data[commit_reg] <= commit_value;
			// A younger writer keeps the register busy
			if (producer[commit_reg] == commit_tag)
				busy[commit_reg] <= 1'b0;
		end
		if (ld_busy)
			busy[dest] <= 1'b1; // Overrides a same-cycle commit
	end
end

always_ff @(posedge clk)
begin
	if (ld_busy)
		producer[dest] <= rob_entry;
end

assign sr1_out = '{busy: busy[sr1], rob_entry: producer[sr1], data: data[sr1]};
assign sr2_out = '{busy: busy[sr2], rob_entry: producer[sr2], data: data[sr2]};

endmodule

//--- logic/reorder_buffer.sv
`include "ooo_defines.svh"

module reorder_buffer
(
	input logic clk,
	input logic arst_n,
	input logic write_enable,
	input lc3b_types::lc3b_opcode opcode,
	input lc3b_types::lc3b_reg dest,
	input lc3b_types::cdb_t cdb_in,
	input lc3b_types::lc3b_rob_addr sr1_tag,
	input lc3b_types::lc3b_rob_addr sr2_tag,
	output lc3b_types::lc3b_rob_addr rob_addr,
	output logic full,
	output lc3b_types::lc3b_word sr1_value,
	output lc3b_types::lc3b_word sr2_value,
	output logic sr1_valid,
	output logic sr2_valid,
	output logic commit_valid,
	output lc3b_types::lc3b_reg commit_reg,
	output lc3b_types::lc3b_rob_addr commit_tag,
	output lc3b_types::lc3b_word commit_value
);
import lc3b_types::*;

logic [`ROB_DEPTH-1:0] valid;
logic [`ROB_DEPTH-1:0] done;   // Result received from the bus
lc3b_reg dest_q [`ROB_DEPTH];
lc3b_word value_q [`ROB_DEPTH];
lc3b_rob_addr head;
lc3b_rob_addr tail;
logic [`TAG_W:0] count;

assign rob_addr = tail;        // Next free entry
assign full = (count == `ROB_DEPTH);

// Head retires once its result is in
assign commit_valid = valid[head] && done[head];
assign commit_reg = dest_q[head];
assign commit_tag = head;
assign commit_value = value_q[head];

// Operand lookup by producer tag
assign sr1_value = value_q[sr1_tag];
assign sr1_valid = valid[sr1_tag] && done[sr1_tag];
assign sr2_value = value_q[sr2_tag];
assign sr2_valid = valid[sr2_tag] && done[sr2_tag];

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
	begin
		valid <= '0;
		done <= '0;
		head <= '0;
		tail <= '0;
		count <= '0;
	end
	else
	begin
		if (write_enable)
		begin
			valid[tail] <= 1'b1;
			done[tail] <= 1'b0;
			tail <= tail + 1'b1; // Wraps at ROB_DEPTH
		end
		if (cdb_in.valid)
			done[cdb_in.tag] <= 1'b1;
		if (commit_valid)
		begin
			valid[head] <= 1'b0;
			head <= head + 1'b1;
		end
		count <= count + write_enable - commit_valid;
	end
end

always_ff @(posedge clk)
begin
	if (write_enable)
		dest_q[tail] <= dest;
	if (cdb_in.valid)
		value_q[cdb_in.tag] <= cdb_in.data;
end

assert property (@(posedge clk) disable iff (!arst_n) !(write_enable && full));

// Only ALU instructions are allocated
assert property (@(posedge clk) disable iff (!arst_n)
	write_enable |-> opcode inside {op_add, op_and, op_not});

// Each live entry sees exactly one broadcast
assert property (@(posedge clk) disable iff (!arst_n)
	cdb_in.valid |-> valid[cdb_in.tag] && !done[cdb_in.tag]);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ooo_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	-f vlog.f --top-module ooo_core_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vooo_core_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0

//--- verif/ooo_core_tb.sv
module ooo_core_tb;
timeunit 1ns;
timeprecision 100ps;
import lc3b_types::*;

localparam string VECTOR_FILE = "verif/ooo_core_vectors.txt";
localparam int ISSUE_TIMEOUT = 200;  // Cycles an instruction may wait for issue_ready
localparam int DRAIN_TIMEOUT = 500;
localparam int IDLE_CYCLES = 20;     // Quiet window for stray commits

logic clk;
logic arst_n;
lc3b_word instr;
logic instr_is_new;
logic issue_ready;
logic commit_valid;
lc3b_reg commit_reg;
lc3b_word commit_value;

// Expected commits in program order
lc3b_reg exp_reg_q [$];
lc3b_word exp_value_q [$];
logic stall_seen;

ooo_core ooo_core_inst (
	.clk,
	.arst_n,
	.instr,
	.instr_is_new,
	.issue_ready,
	.commit_valid,
	.commit_reg,
	.commit_value
);

always #2 clk = ~clk;

task automatic stop_with_failure(input string reason);
	$display("%s", reason);
	$display("STATUS: FAIL");
	$fatal(1, "Simulation stopped on error");
endtask

task automatic check_flag(input string name, input logic actual, input logic expected);
	if (actual !== expected)
		stop_with_failure($sformatf("Error: %s is 0x%h, expected 0x%h", name, actual, expected));
endtask

task automatic check_reg(input string name, input lc3b_reg actual, input lc3b_reg expected);
	if (actual !== expected)
		stop_with_failure($sformatf("Error: %s is 0x%h, expected 0x%h", name, actual, expected));
endtask

task automatic check_word(input string name, input lc3b_word actual, input lc3b_word expected);
	if (actual !== expected)
		stop_with_failure($sformatf("Error: %s is 0x%h, expected 0x%h", name, actual, expected));
endtask

// Hold the word until a rising edge sees issue_ready high
task automatic issue_instr(input lc3b_word word);
	int waited;
	waited = 0;
	instr <= word;
	instr_is_new <= 1'b1;
	@(negedge clk);
	while (!issue_ready)
	begin
		stall_seen = 1'b1;
		waited++;
		if (waited > ISSUE_TIMEOUT)
			stop_with_failure("Timed out waiting for issue_ready to rise");
		@(negedge clk);
	end
	@(posedge clk); // Taken here
endtask

// Commit outputs are stable by the falling edge
always @(negedge clk)
begin
	if (arst_n && commit_valid)
	begin
		if (exp_reg_q.size() == 0)
			stop_with_failure("A commit appeared with no instruction left to commit");
		else
		begin
			check_reg("commit_reg", commit_reg, exp_reg_q.pop_front());
			check_word("commit_value", commit_value, exp_value_q.pop_front());
		end
	end
end

initial
begin
	int fd;
	int n;
	int waited;
	string line;
	lc3b_word word;
	logic commits;
	lc3b_reg dest;
	lc3b_word value;
	clk = 1'b0;
	arst_n = 1'b0;
	instr = '0;
	instr_is_new = 1'b0;
	stall_seen = 1'b0;
	repeat (5) @(posedge clk);
	arst_n <= 1'b1;
	@(negedge clk);
	check_flag("commit_valid", commit_valid, 1'b0);
	check_flag("issue_ready", issue_ready, 1'b1);

	fd = $fopen(VECTOR_FILE, "r");
	if (fd == 0)
		stop_with_failure("Could not open the vector file");
	@(posedge clk);
	while (!$feof(fd))
	begin
		line = "";
		n = $fgets(line, fd);
		// Skip blank and comment lines
		if (n == 0 || line.len() < 2 || line.getc(0) == "#")
			continue;
		n = $sscanf(line, "%h %h %h %h", word, commits, dest, value);
		if (n != 4)
			stop_with_failure("Malformed line in the vector file");
		if (commits)
		begin
			exp_reg_q.push_back(dest);
			exp_value_q.push_back(value);
		end
		issue_instr(word);
	end
	$fclose(fd);
	instr_is_new <= 1'b0;
	instr <= '0;

	waited = 0;
	while (exp_reg_q.size() != 0)
	begin
		waited++;
		if (waited > DRAIN_TIMEOUT)
			stop_with_failure("Timed out waiting for the remaining commits");
		@(posedge clk);
	end
	repeat (IDLE_CYCLES) @(posedge clk);

	if (!stall_seen)
		stop_with_failure("issue_ready never went low while instructions were waiting");
	else
	begin
		$display("STATUS: PASS");
		$finish;
	end
end

endmodule

//--- verif/ooo_core_vectors.txt
# Columns in hex: instruction, commits (1 or 0), destination register, value
# Non-ALU lines commit nothing and carry zero in the last two columns
1225 1 1 0005  ADD R1, R0, #5
143D 1 2 FFFD  ADD R2, R0, #-3
56A7 1 3 0005  AND R3, R2, #7
1261 1 1 0006  ADD R1, R1, #1
1262 1 1 0008  ADD R1, R1, #2
1843 1 4 000D  ADD R4, R1, R3
5B01 1 5 0008  AND R5, R4, R1
9D7F 1 6 FFF7  NOT R6, R5
1F82 1 7 FFF4  ADD R7, R6, R2
51C6 1 0 FFF4  AND R0, R7, R6
0E02 0 0 0000  BR
6283 0 0 0000  LDR
F025 0 0 0000  TRAP
1261 1 1 0009  ADD R1, R1, #1
1241 1 1 0012  ADD R1, R1, R1
1261 1 1 0013  ADD R1, R1, #1
1241 1 1 0026  ADD R1, R1, R1
127F 1 1 0025  ADD R1, R1, #-1
526F 1 1 0005  AND R1, R1, #15
1241 1 1 000A  ADD R1, R1, R1
1263 1 1 000D  ADD R1, R1, #3
947F 1 2 FFF2  NOT R2, R1
1681 1 3 FFFF  ADD R3, R2, R1
1020 1 0 FFF4  ADD R0, R0, #0

//--- vlog.f
+incdir+logic
logic/lc3b_types.sv
logic/ooo_ifs.sv
logic/issue_control.sv
logic/reg_status_file.sv
logic/reorder_buffer.sv
logic/alu_station.sv
logic/cdb_arbiter.sv
logic/ooo_core.sv
verif/ooo_core_tb.sv
